/* verilog/busPkg.sv */
package busPkg;

   ////////////////////////////////////////////////////////////
   // Bus word layout, bit 0 is the most significant bit
   ////////////////////////////////////////////////////////////

   localparam int busWordBits = 36;         // Backplane word width

   // Operation flags in the address word
   localparam int busFlagRead   = 3;        // Read cycle
   localparam int busFlagWrTest = 4;        // Write test
   localparam int busFlagWrite  = 5;        // Write cycle
   localparam int busFlagPhys   = 8;        // Physical reference
   localparam int busFlagIo     = 10;       // I/O space reference

   // Device field sits just above the I/O address
   localparam int busDevMsb = 14;
   localparam int busDevLsb = 17;

   localparam int busIoAddrBits  = 18;      // Bits 18 to 35
   localparam int busMemAddrBits = 20;      // Bits 16 to 35

   // Operation decoded from the flag bits
   typedef enum logic [1:0]
   {
      opNone,
      opRead,
      opWrite,
      opWrTest
   } busOpType;

   localparam logic [0:3] memDevNum = 4'd0;                       // Memory is device 0
   localparam logic [0:busIoAddrBits-1] msrIoAddr = 18'o100000;   // MSR in I/O space

endpackage

/* verilog/memPkg.sv */
package memPkg;

   ////////////////////////////////////////////////////////////
   // Memory cycle phases
   ////////////////////////////////////////////////////////////

   localparam int phaseCount = 4;           // Width of the one-hot phase

   typedef enum logic [1:0]
   {
      phase1,                               // Capture address and data
      phase2,
      phase3,                               // Array write and read address
      phase4                                // Read word valid
   } phaseType;

   ////////////////////////////////////////////////////////////
   // High-speed block and status register
   ////////////////////////////////////////////////////////////

   // HSB occupies 32 words at octal 376000
   localparam int hsbAddrBits = 5;
   localparam logic [0:14] hsbBase = 15'(20'o0376000 >> hsbAddrBits);

   // NXM is sticky and write-one-to-clear
   localparam int msrNxmBit = 2;

   // Writable control bits, never includes NXM
   localparam logic [0:35] msrWriteMask = 36'o034000_000001;

endpackage

/* verilog/memPhase.sv */
module memPhase import memPkg::*;
(
   input  logic                rst,
   input  logic                memCLK,
   output logic [1:phaseCount] phase         // One-hot, bit 1 is phase 1
);

   phaseType phaseState;

   // Free-running rotation
   always_ff @(posedge memCLK or posedge rst)
   begin
      if (rst)
         phaseState <= phase1;
      else
      begin
         case (phaseState)
            phase1  : phaseState <= phase2;
            phase2  : phaseState <= phase3;
            phase3  : phaseState <= phase4;
            default : phaseState <= phase1; // Wrap after phase 4
         endcase
      end
   end

   // One-hot decode for the bus and the arrays
   always_comb
   begin
      phase = '0;
      case (phaseState)
         phase1  : phase[1] = 1'b1;
         phase2  : phase[2] = 1'b1;
         phase3  : phase[3] = 1'b1;
         default : phase[4] = 1'b1;
      endcase
   end

endmodule

/* verilog/memDecode.sv */
module memDecode import busPkg::*; import memPkg::*;
#(
   parameter int memAddrBits = 15
)
(
   input  logic                      busReq,
   input  logic [0:busWordBits-1]    busAddrIn,
   input  logic [1:phaseCount]       phase,
   output logic                      busAck,
   output logic                      msrWrite,     // Phase 4 only
   output logic                      memWrite,
   output logic [0:busMemAddrBits-1] memAddr,
   output logic                      isHsb,
   output logic                      selIo,
   output logic                      selMain,
   output logic                      nxmHit        // Phase 4 only
);

   localparam int upperBits = busMemAddrBits - memAddrBits;  // Bits above the main array

   logic [0:3]               busDev;
   logic [0:busIoAddrBits-1] ioAddr;
   logic                     busIo;
   logic                     msrHit;
   logic                     inMain;
   busOpType                 busOp;

   // Address word fields
   assign busIo   = busAddrIn[busFlagIo];
   assign busDev  = busAddrIn[busDevMsb:busDevLsb];
   assign ioAddr  = busAddrIn[busWordBits-busIoAddrBits:busWordBits-1];
   assign memAddr = busAddrIn[busWordBits-busMemAddrBits:busWordBits-1];

   // Write test beats write, write beats read
   always_comb
   begin
      if (busAddrIn[busFlagWrTest])
         busOp = opWrTest;
      else if (busAddrIn[busFlagWrite])
         busOp = opWrite;
      else if (busAddrIn[busFlagRead])
         busOp = opRead;
      else
         busOp = opNone;
   end

   ////////////////////////////////////////////////////////////
   // Region and register match
   ////////////////////////////////////////////////////////////

   assign msrHit = busIo & busAddrIn[busFlagPhys] & (busDev == memDevNum) & (ioAddr == msrIoAddr);
   assign inMain = (memAddr[0:upperBits-1] == '0);
   assign isHsb  = (memAddr[0:busMemAddrBits-hsbAddrBits-1] == hsbBase);

   assign selIo   = busIo;                  // Read mux select
   assign selMain = inMain;

   // Writes are accepted anywhere but only land in a real region
   assign memWrite = busReq & ~busIo & (busOp == opWrite) & (inMain | isHsb);

   always_comb
   begin
      busAck = 1'b0;
      if (busReq)
      begin
         if (msrHit)
            busAck = (busOp == opRead) | (busOp == opWrite);
         else if (~busIo)
            busAck = (busOp == opWrite) | (busOp == opWrTest)
                   | ((busOp == opRead) & (inMain | isHsb));
      end
   end

   assign msrWrite = busReq & msrHit & (busOp == opWrite) & phase[4];
   assign nxmHit   = busReq & ~busIo & (busOp == opRead) & ~(inMain | isHsb) & phase[4];

endmodule

/* verilog/memStat.sv */
module memStat import busPkg::*; import memPkg::*;
(
   input  logic                   rst,
   input  logic                   memCLK,
   input  logic                   msrWrite,
   input  logic                   nxmHit,
   input  logic [0:busWordBits-1] busDataIn,
   output logic [0:busWordBits-1] regStat
);

   logic [0:busWordBits-1] ctrlBits;       // Writable control field
   logic                   nxmFlag;        // Sticky nonexistent memory

   ////////////////////////////////////////////////////////////
   // Control bits
   ////////////////////////////////////////////////////////////

   always_ff @(posedge memCLK or posedge rst)
   begin
      if (rst)
         ctrlBits <= '0;
      else if (msrWrite)
         ctrlBits <= busDataIn & msrWriteMask;   // Only writable bits stick
   end

   // NXM set has priority over the write-one clear
   always_ff @(posedge memCLK or posedge rst)
   begin
      if (rst)
         nxmFlag <= 1'b0;
      else if (nxmHit)
         nxmFlag <= 1'b1;
      else if (msrWrite & busDataIn[msrNxmBit])
         nxmFlag <= 1'b0;
   end

   // Assemble the register image
   always_comb
   begin
      regStat            = ctrlBits;
      regStat[msrNxmBit] = nxmFlag;
   end

endmodule

/* verilog/memArray.sv */
module memArray import busPkg::*; import memPkg::*;
#(
   parameter int memAddrBits = 15
)
(
   input  logic                      rst,
   input  logic                      memCLK,
   input  logic [1:phaseCount]       phase,
   input  logic                      memWrite,
   input  logic                      isHsb,
   input  logic [0:busMemAddrBits-1] memAddr,
   input  logic [0:busWordBits-1]    busDataIn,
   output logic [0:busWordBits-1]    mainRead,
   output logic [0:busWordBits-1]    hsbRead
);

   localparam int mainDepth = 1 << memAddrBits;
   localparam int hsbDepth  = 1 << hsbAddrBits;

   logic                      wrLatch;      // Captured write level
   logic                      hsbLatch;     // Captured region
   logic [0:busMemAddrBits-1] addrLatch;
   logic [0:busWordBits-1]    dataLatch;

   logic [0:memAddrBits-1]    mainWrAddr;
   logic [0:hsbAddrBits-1]    hsbWrAddr;
   logic [0:memAddrBits-1]    mainRdAddr;
   logic [0:hsbAddrBits-1]    hsbRdAddr;

   logic [0:busWordBits-1]    mainMem [0:mainDepth-1];
   logic [0:busWordBits-1]    hsbMem  [0:hsbDepth-1];

   ////////////////////////////////////////////////////////////
   // Phase 1 capture
   ////////////////////////////////////////////////////////////

   always_ff @(posedge memCLK or posedge rst)
   begin
      if (rst)
      begin
         wrLatch  <= 1'b0;
         hsbLatch <= 1'b0;
      end
      else if (phase[1])
      begin
         wrLatch  <= memWrite;
         hsbLatch <= isHsb;
      end
   end

   // Address and data held for the rest of the cycle
   always_ff @(posedge memCLK)
   begin
      if (phase[1])
      begin
         addrLatch <= memAddr;
         dataLatch <= busDataIn;
      end
   end

   // Low address bits index each array
   assign mainWrAddr = addrLatch[busMemAddrBits-memAddrBits:busMemAddrBits-1];
   assign hsbWrAddr  = addrLatch[busMemAddrBits-hsbAddrBits:busMemAddrBits-1];

   ////////////////////////////////////////////////////////////
   // Phase 3 write and read address
   ////////////////////////////////////////////////////////////

   always_ff @(posedge memCLK)
   begin
      if (phase[3])
      begin
         if (wrLatch & ~hsbLatch)
            mainMem[mainWrAddr] <= dataLatch;
         if (wrLatch & hsbLatch)
            hsbMem[hsbWrAddr] <= dataLatch;
         mainRdAddr <= mainWrAddr;
         hsbRdAddr  <= hsbWrAddr;          // Both tracked, mux picks later
      end
   end

   assign mainRead = mainMem[mainRdAddr];   // Valid from phase 4
   assign hsbRead  = hsbMem[hsbRdAddr];

endmodule

/* verilog/memSubsys.sv */
module memSubsys import busPkg::*; import memPkg::*;
#(
   parameter int memAddrBits = 15
)
(
   input  logic                   rst,
   input  logic                   memCLK,
   input  logic                   busReq,
   input  logic [0:busWordBits-1] busAddrIn,
   input  logic [0:busWordBits-1] busDataIn,
   output logic                   busAck,
   output logic [0:busWordBits-1] busDataOut,
   output logic [1:phaseCount]    busPhase
);

   logic                      msrWrite;
   logic                      memWrite;
   logic [0:busMemAddrBits-1] memAddr;
   logic                      isHsb;
   logic                      selIo;
   logic                      selMain;
   logic                      nxmHit;
   logic [0:busWordBits-1]    regStat;
   logic [0:busWordBits-1]    mainRead;
   logic [0:busWordBits-1]    hsbRead;

   ////////////////////////////////////////////////////////////
   // Sequencer, decode, status and arrays
   ////////////////////////////////////////////////////////////

   memPhase phase0
   (
      .rst    (rst),
      .memCLK (memCLK),
      .phase  (busPhase)                    // Also shown to the master
   );

   memDecode #(.memAddrBits(memAddrBits)) decode0
   (
      .busReq    (busReq),
      .busAddrIn (busAddrIn),
      .phase     (busPhase),
      .busAck    (busAck),
      .msrWrite  (msrWrite),
      .memWrite  (memWrite),
      .memAddr   (memAddr),
      .isHsb     (isHsb),
      .selIo     (selIo),
      .selMain   (selMain),
      .nxmHit    (nxmHit)
   );

   memStat stat0
   (
      .rst       (rst),
      .memCLK    (memCLK),
      .msrWrite  (msrWrite),
      .nxmHit    (nxmHit),
      .busDataIn (busDataIn),
      .regStat   (regStat)
   );

   memArray #(.memAddrBits(memAddrBits)) array0
   (
      .rst       (rst),
      .memCLK    (memCLK),
      .phase     (busPhase),
      .memWrite  (memWrite),
      .isHsb     (isHsb),
      .memAddr   (memAddr),
      .busDataIn (busDataIn),
      .mainRead  (mainRead),
      .hsbRead   (hsbRead)
   );

   // Read word select
   always_comb
   begin
      if (selIo)
         busDataOut = regStat;              // MSR while request held
      else if (selMain)
         busDataOut = mainRead;
      else
         busDataOut = hsbRead;
   end

endmodule

/* tb/memTb.sv */
module memTb;

   ////////////////////////////////////////////////////////////
   // DUT hookup and clock
   ////////////////////////////////////////////////////////////

   logic        rst;
   logic        memCLK;
   logic        busReq;
   logic [0:35] busAddrIn;
   logic [0:35] busDataIn;
   logic        busAck;
   logic [0:35] busDataOut;
   logic [1:4]  busPhase;                  // One-hot with bit 1 as phase 1

   integer      seed;                      // Random write words
   logic [0:35] shadow [0:7];              // Saved random words by slot

   memSubsys #(.memAddrBits(10)) dut0
   (
      .rst        (rst),
      .memCLK     (memCLK),
      .busReq     (busReq),
      .busAddrIn  (busAddrIn),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .busPhase   (busPhase)
   );

   // Period 4
   initial
   begin
      memCLK = 1'b0;
      forever #2 memCLK = ~memCLK;
   end

   // Stop at the first mismatch
   task automatic compareWord(input logic [0:35] actual, input logic [0:35] expected,
                              input string what);
   begin
      if (actual !== expected)
      begin
         $display("** Error at time %0t: %s, got %o, expected %o",
                  $time, what, actual, expected);
         $display("*** TEST FAILED ***");
         $fatal(1, "Stopped on the first mismatch");
      end
   end
   endtask

   // One cycle at a time until the sequencer is back in phase 1
   task automatic waitPhaseOne();
      integer cycles;
   begin
      cycles = 0;
      @(posedge memCLK);
      #1;                                  // Drive point after the edge
      while (!busPhase[1])
      begin
         cycles = cycles + 1;
         if (cycles > 8)
         begin
            $display("Timeout: busPhase did not show phase 1 within 8 cycles");
            $display("*** TEST FAILED ***");
            $fatal(1, "Phase wait timed out");
         end
         @(posedge memCLK);
         #1;
      end
   end
   endtask

   ////////////////////////////////////////////////////////////
   // One bus transaction from the test file
   ////////////////////////////////////////////////////////////

   task automatic runLine(input integer lineNo, input integer op,
                          input logic [0:35] addrWord, input logic [0:35] wordIn,
                          input integer slot, input integer ackExp,
                          input logic [0:35] expWord);
      logic [0:35] writeWord;
      logic [0:35] wantWord;
      logic [31:0] rndLo;
      logic [31:0] rndHi;
   begin
      writeWord = wordIn;
      wantWord  = expWord;
      if (slot != 0 && op == 0)
      begin
         rndLo        = $random(seed);
         rndHi        = $random(seed);
         writeWord    = {rndHi[3:0], rndLo};   // 36-bit random word
         shadow[slot] = writeWord;             // Kept for the read back
      end
      else if (slot != 0)
         wantWord = shadow[slot];
      waitPhaseOne();
      busReq    = 1'b1;
      busAddrIn = addrWord;
      busDataIn = writeWord;
      #1;                                      // Mid phase 1
      compareWord(36'(busAck), 36'(ackExp), $sformatf("line %0d acknowledge", lineNo));
      repeat (3) @(posedge memCLK);            // Hold through phases 2 to 4
      #2;
      compareWord(36'(busPhase), 36'd1, $sformatf("line %0d not in phase 4", lineNo));
      // Read word only exists for accepted reads and write tests
      if (op != 0 && ackExp != 0)
         compareWord(busDataOut, wantWord, $sformatf("line %0d read word", lineNo));
   end
   endtask

   ////////////////////////////////////////////////////////////
   // Reset, then walk the test file
   ////////////////////////////////////////////////////////////

   initial
   begin
      integer           fd;
      integer           count;
      integer           lineNo;
      integer           runCount;
      integer           op;
      integer           slot;
      integer           ackExp;
      logic [0:35]      addrWord;
      logic [0:35]      wordIn;
      logic [0:35]      expWord;
      logic [8*256-1:0] lineText;
      rst       = 1'b1;
      busReq    = 1'b0;
      busAddrIn = '0;
      busDataIn = '0;
      seed      = 85;
      lineNo    = 0;
      runCount  = 0;
      fd = $fopen("tb/memTests.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the test file tb/memTests.txt");
         $display("*** TEST FAILED ***");
         $fatal(1, "No stimulus file");
      end
      repeat (8) @(posedge memCLK);            // 8 cycles of reset
      #1;
      rst = 1'b0;
      while (!$feof(fd))
      begin
         lineText = '0;
         count    = $fgets(lineText, fd);
         lineNo   = lineNo + 1;
         // Comment and blank lines give fewer than six fields
         count = $sscanf(lineText, "%d %o %o %d %d %o",
                         op, addrWord, wordIn, slot, ackExp, expWord);
         if (count == 6)
         begin
            if (slot < 0 || slot > 7)
            begin
               $display("Line %0d of tb/memTests.txt has a slot outside 0 to 7", lineNo);
               $display("*** TEST FAILED ***");
               $fatal(1, "Bad test line");
            end
            runLine(lineNo, op, addrWord, wordIn, slot, ackExp, expWord);
            runCount = runCount + 1;
         end
      end
      $fclose(fd);
      waitPhaseOne();
      busReq = 1'b0;                           // Bus idle again
      #1;
      // Last accepted request still on the address lines
      compareWord(36'(busAck), 36'd0, "acknowledge with busReq low");
      if (runCount > 0)
      begin
         $display("*** TEST PASSED ***");
         $finish;
      end
      else
      begin
         $display("No transactions were read from tb/memTests.txt");
         $display("*** TEST FAILED ***");
         $fatal(1, "Empty stimulus file");
      end
   end

endmodule

/* tb/memTests.txt */
# op (0 write 1 read 2 write test) then address word, write word (octal), slot, ack, read word (octal)
# A nonzero slot on a write stores a random word there and on a read expects that word
1 041200100000 000000000000 0 1 000000000000
# Main array write and read back
0 010000000100 123456701234 0 1 000000000000
0 010000001777 000000000000 1 1 000000000000
1 040000000100 000000000000 0 1 123456701234
1 040000001777 000000000000 1 1 000000000000
# High-speed block next to main address 5
0 010000000005 525252525252 0 1 000000000000
0 010000376005 000000000000 2 1 000000000000
0 010000376037 707070707070 0 1 000000000000
1 040000376005 000000000000 2 1 000000000000
1 040000000005 000000000000 0 1 525252525252
1 040000376037 000000000000 0 1 707070707070
# MSR keeps only the writable bits
0 011200100000 777777777777 0 1 000000000000
1 041200100000 000000000000 0 1 034000000001
0 011200100000 123456765432 0 1 000000000000
1 041200100000 000000000000 0 1 020000000000
# Wrong device or wrong I/O address
1 041201100000 000000000000 0 0 000000000000
1 041200100001 000000000000 0 0 000000000000
0 011201100000 777777777777 0 0 000000000000
1 041200100000 000000000000 0 1 020000000000
# Nonexistent read sets NXM and a written one clears it
1 040000002000 000000000000 0 0 000000000000
1 041200100000 000000000000 0 1 120000000000
0 011200100000 100000000000 0 1 000000000000
1 041200100000 000000000000 0 1 000000000000
# Write beyond the array lands nowhere
0 010000001000 222222222222 0 1 000000000000
0 010000003000 111111111111 0 1 000000000000
1 040000001000 000000000000 0 1 222222222222
1 041200100000 000000000000 0 1 000000000000
# Write test returns the stored word and changes nothing
2 020000000100 666666666666 0 1 123456701234
1 040000000100 000000000000 0 1 123456701234
2 020000376037 123123123123 0 1 707070707070
1 040000376037 000000000000 0 1 707070707070

/* memSubsys.f */
verilog/busPkg.sv
verilog/memPkg.sv
verilog/memPhase.sv
verilog/memDecode.sv
verilog/memStat.sv
verilog/memArray.sv
verilog/memSubsys.sv
tb/memTb.sv

/* run.sh */
#!/bin/sh
# Build the memory controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=memSim.log

verilator --binary --timing --top-module memTb -f memSubsys.f -o memSim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/memSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0
